//--- rtl/mem_cfg.svh
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// Data path width in bits
`define MEM_DW 32

// Word address width, 256 words
`define MEM_AW 8

// Request queue depth, also the credits a port starts with
`define MEM_FIFO_DEPTH 4

// Peer load/store ports on the shared RAM
`define MEM_PORTS 2

`endif

//--- rtl/mem_pkg.sv
`include "mem_cfg.svh"

package mem_pkg;

    // Bit 3 set marks a store
    typedef enum logic [3:0] {
        LS_SEL_LB  = 4'h0,
        LS_SEL_LBU = 4'h1,
        LS_SEL_LH  = 4'h2,
        LS_SEL_LHU = 4'h3,
        LS_SEL_LW  = 4'h4,
        LS_SEL_LWL = 4'h5,
        LS_SEL_LWR = 4'h6,
        LS_SEL_SB  = 4'h8,
        LS_SEL_SH  = 4'h9,
        LS_SEL_SW  = 4'ha,
        LS_SEL_SWL = 4'hb,
        LS_SEL_SWR = 4'hc
    } ls_sel_e;

    typedef logic [$clog2(`MEM_PORTS)-1:0] port_t;

    typedef struct packed {
        ls_sel_e           sel;
        logic [31:0]       addr;           // Byte address
        logic [`MEM_DW-1:0] rt_data;
        logic              has_exception;
        logic              refetch;
    } ls_req_t;

    // What the read side needs to finish a load
    typedef struct packed {
        ls_sel_e            sel;
        logic [1:0]         lo;
        logic [`MEM_DW-1:0] rt_data;
    } ld_ctx_t;

    typedef struct packed {
        logic                 wr;
        logic [`MEM_AW-1:0]   addr;        // Word address
        logic [`MEM_DW/8-1:0] be;
        logic [`MEM_DW-1:0]   wdata;
        ld_ctx_t              ctx;
    } ram_req_t;

    typedef struct packed {
        port_t              port;
        logic [`MEM_DW-1:0] rdata;
        ld_ctx_t            ctx;
    } ram_rsp_t;

endpackage

//--- rtl/mem_ctrl.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_ctrl (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req_valid,
    input  mem_pkg::ls_req_t   req,
    output logic               push,
    output mem_pkg::ram_req_t  push_data,
    output logic               drop_credit
);
    import mem_pkg::*;

    logic       kill;
    logic [1:0] lo;
    ram_req_t   fmt;

    assign kill = req.has_exception | req.refetch;
    assign lo   = req.addr[1:0];

    always_comb begin
        fmt             = '0;
        fmt.addr        = req.addr[`MEM_AW+1:2];
        fmt.ctx.sel     = req.sel;
        fmt.ctx.lo      = lo;
        fmt.ctx.rt_data = req.rt_data;
        case (req.sel)
            LS_SEL_SB: begin
                fmt.wr    = 1'b1;
                fmt.be    = 4'b0001 << lo;
                fmt.wdata = {4{req.rt_data[7:0]}};
            end
            LS_SEL_SH: begin
                fmt.wr    = 1'b1;
                fmt.be    = lo[1] ? 4'b1100 : 4'b0011;
                fmt.wdata = {2{req.rt_data[15:0]}};
            end
            LS_SEL_SW: begin
                fmt.wr    = 1'b1;
                fmt.be    = 4'b1111;
                fmt.wdata = req.rt_data;
            end
            LS_SEL_SWL: begin
                // High bytes of rt land from lane 0 up to the addressed lane
                fmt.wr    = 1'b1;
                fmt.be    = 4'b1111 >> (2'd3 - lo);
                fmt.wdata = req.rt_data >> {2'd3 - lo, 3'b000};
            end
            LS_SEL_SWR: begin
                fmt.wr    = 1'b1;
                fmt.be    = 4'b1111 << lo;
                fmt.wdata = req.rt_data << {lo, 3'b000};
            end
            default: begin
                fmt.wr    = 1'b0;   // Loads go out as plain reads
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            push        <= 1'b0;
            drop_credit <= 1'b0;
        end else begin
            push        <= req_valid & ~kill;
            drop_credit <= req_valid & kill;   // Credit back, no access
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            push_data <= fmt;
        end
    end

endmodule

//--- rtl/credit_fifo.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module credit_fifo #(
    parameter int  DEPTH     = `MEM_FIFO_DEPTH,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     credit
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t                     slots [DEPTH];
    logic [PW-1:0]                wr_ptr;
    logic [PW-1:0]                rd_ptr;
    logic [$clog2(DEPTH+1)-1:0]   count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_data;
        end
    end

    assign pop_data = slots[rd_ptr];
    assign empty    = (count == '0);
    assign credit   = pop;   // Slot freed, sender may reuse it

endmodule

//--- rtl/data_arbiter.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module data_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`MEM_PORTS-1:0]  empty,
    input  mem_pkg::ram_req_t      req_in [`MEM_PORTS],
    output logic [`MEM_PORTS-1:0]  pop,
    output logic                   ram_en,
    output mem_pkg::ram_req_t      ram_req,
    output mem_pkg::port_t         ram_port,
    input  logic                   rsp_in_valid,
    input  mem_pkg::ram_rsp_t      rsp_in,
    output logic [`MEM_PORTS-1:0]  rsp_valid,
    output mem_pkg::ram_rsp_t      rsp_out [`MEM_PORTS]
);
    import mem_pkg::*;

    port_t prio;   // Port checked first this cycle
    port_t win;

    always_comb begin
        int idx;
        pop = '0;
        win = prio;
        for (int i = 0; i < `MEM_PORTS; i++) begin
            idx = (int'(prio) + i) % `MEM_PORTS;
            if (pop == '0 && !empty[idx]) begin
                pop[idx] = 1'b1;
                win      = port_t'(idx);
            end
        end
    end

    assign ram_en   = |pop;
    assign ram_req  = req_in[win];
    assign ram_port = win;

    // Winner drops to lowest priority
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prio <= '0;
        end else if (ram_en) begin
            prio <= (win == port_t'(`MEM_PORTS - 1)) ? '0 : port_t'(win + 1'b1);
        end
    end

    // Read returns go back by tag
    always_comb begin
        for (int p = 0; p < `MEM_PORTS; p++) begin
            rsp_valid[p] = rsp_in_valid && (rsp_in.port == port_t'(p));
            rsp_out[p]   = rsp_in;
        end
    end

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module data_ram (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  mem_pkg::ram_req_t  req,
    input  mem_pkg::port_t     port,
    output logic               rsp_valid,
    output mem_pkg::ram_rsp_t  rsp
);
    logic [`MEM_DW-1:0] mem [2**`MEM_AW];

    always_ff @(posedge clk) begin
        if (en && req.wr) begin
            for (int b = 0; b < `MEM_DW/8; b++) begin
                if (req.be[b]) begin
                    mem[req.addr][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= en & ~req.wr;   // Reads only
        end
    end

    always_ff @(posedge clk) begin
        if (en && !req.wr) begin
            rsp.port  <= port;
            rsp.rdata <= mem[req.addr];
            rsp.ctx   <= req.ctx;
        end
    end

endmodule

//--- rtl/load_align.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module load_align (
    input  mem_pkg::ram_rsp_t   rsp,
    output logic [`MEM_DW-1:0]  rsp_data
);
    import mem_pkg::*;

    logic [`MEM_DW-1:0] word;
    logic [`MEM_DW-1:0] rt;
    logic [1:0]         lo;
    logic [7:0]         byte_v;
    logic [15:0]        half_v;
    logic [4:0]         l_sh;   // LWL shift, bytes kept from rt below
    logic [4:0]         r_sh;

    assign word   = rsp.rdata;
    assign rt     = rsp.ctx.rt_data;
    assign lo     = rsp.ctx.lo;
    assign byte_v = word[{lo, 3'b000} +: 8];
    assign half_v = lo[1] ? word[31:16] : word[15:0];
    assign l_sh   = {2'd3 - lo, 3'b000};
    assign r_sh   = {lo, 3'b000};

    always_comb begin
        case (rsp.ctx.sel)
            LS_SEL_LB: begin
                rsp_data = {{24{byte_v[7]}}, byte_v};
            end
            LS_SEL_LBU: begin
                rsp_data = {24'h0, byte_v};
            end
            LS_SEL_LH: begin
                rsp_data = {{16{half_v[15]}}, half_v};
            end
            LS_SEL_LHU: begin
                rsp_data = {16'h0, half_v};
            end
            LS_SEL_LWL: begin
                // Low memory bytes fill rt from the top
                rsp_data = (word << l_sh) | (rt & ~(32'hffff_ffff << l_sh));
            end
            LS_SEL_LWR: begin
                rsp_data = (word >> r_sh) | (rt & ~(32'hffff_ffff >> r_sh));
            end
            default: begin
                rsp_data = word;   // LW
            end
        endcase
    end

endmodule

//--- rtl/mem_subsys.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_subsys (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`MEM_PORTS-1:0]  req_valid,
    input  mem_pkg::ls_req_t       req [`MEM_PORTS],
    output logic [`MEM_PORTS-1:0]  credit,
    output logic [`MEM_PORTS-1:0]  rsp_valid,
    output logic [`MEM_DW-1:0]     rsp_data [`MEM_PORTS]
);
    import mem_pkg::*;

    logic [`MEM_PORTS-1:0] push;
    logic [`MEM_PORTS-1:0] drop_credit;
    logic [`MEM_PORTS-1:0] fifo_credit;
    logic [`MEM_PORTS-1:0] fifo_empty;
    logic [`MEM_PORTS-1:0] arb_empty;
    logic [`MEM_PORTS-1:0] pop;
    ram_req_t              push_data [`MEM_PORTS];
    ram_req_t              pop_data [`MEM_PORTS];
    logic                  ram_en;
    ram_req_t              ram_req;
    port_t                 ram_port;
    logic                  ram_rsp_valid;
    ram_rsp_t              ram_rsp;
    ram_rsp_t              rsp_out [`MEM_PORTS];

    for (genvar p = 0; p < `MEM_PORTS; p++) begin : g_port
        mem_ctrl u_mem_ctrl (
            .clk         (clk),
            .rst_n       (rst_n),
            .req_valid   (req_valid[p]),
            .req         (req[p]),
            .push        (push[p]),
            .push_data   (push_data[p]),
            .drop_credit (drop_credit[p])
        );

        credit_fifo #(
            .DEPTH     (`MEM_FIFO_DEPTH),
            .payload_t (ram_req_t)
        ) u_credit_fifo (
            .clk       (clk),
            .rst_n     (rst_n),
            .push      (push[p]),
            .push_data (push_data[p]),
            .pop       (pop[p]),
            .pop_data  (pop_data[p]),
            .empty     (fifo_empty[p]),
            .credit    (fifo_credit[p])
        );

        load_align u_load_align (
            .rsp      (rsp_out[p]),
            .rsp_data (rsp_data[p])
        );
    end

    // Port sits out arbitration while its drop credit goes out, so the OR loses nothing
    assign arb_empty = fifo_empty | drop_credit;
    assign credit    = fifo_credit | drop_credit;

    data_arbiter u_data_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .empty        (arb_empty),
        .req_in       (pop_data),
        .pop          (pop),
        .ram_en       (ram_en),
        .ram_req      (ram_req),
        .ram_port     (ram_port),
        .rsp_in_valid (ram_rsp_valid),
        .rsp_in       (ram_rsp),
        .rsp_valid    (rsp_valid),
        .rsp_out      (rsp_out)
    );

    data_ram u_data_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (ram_en),
        .req       (ram_req),
        .port      (ram_port),
        .rsp_valid (ram_rsp_valid),
        .rsp       (ram_rsp)
    );

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verif/mem_subsys_asserts.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_subsys_asserts (
    input logic                  clk,
    input logic                  rst_n,
    input logic [`MEM_PORTS-1:0] credit,
    input logic [`MEM_PORTS-1:0] rsp_valid,
    input logic [`MEM_PORTS-1:0] pop,
    input logic [`MEM_PORTS-1:0] push,
    input logic                  ram_en
);
    int                    fails = 0;
    int                    occ [`MEM_PORTS];   // Queue fill level, rebuilt from push and pop
    logic [`MEM_PORTS-1:0] overflow;

    always_ff @(posedge clk) begin
        for (int p = 0; p < `MEM_PORTS; p++) begin
            occ[p] <= !rst_n ? 0 : occ[p] + int'(push[p]) - int'(pop[p]);
        end
    end

    always_comb begin
        for (int p = 0; p < `MEM_PORTS; p++) begin
            overflow[p] = push[p] && !pop[p] && (occ[p] == `MEM_FIFO_DEPTH);
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (credit == '0 && rsp_valid == '0 && pop == '0 && !ram_en))
        else begin fails++; $error("credit, response or grant active after reset"); end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(pop))
        else begin fails++; $error("more than one queue granted"); end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) overflow == '0)
        else begin fails++; $error("push into a full queue"); end

endmodule

//--- verif/mem_subsys_tb.sv
`timescale 1ns/1ps

`include "mem_cfg.svh"

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int N_REQ = 512;            // Requests over all tests
    localparam int LIMIT = 40 * N_REQ;

    logic                  clk;
    logic                  rst_n;
    logic [`MEM_PORTS-1:0] req_valid;
    ls_req_t               req [`MEM_PORTS];
    logic [`MEM_PORTS-1:0] credit;
    logic [`MEM_PORTS-1:0] rsp_valid;
    logic [`MEM_DW-1:0]    rsp_data [`MEM_PORTS];

    integer      seed = 32'h9a27c719;
    int          cnt [`MEM_PORTS];          // Credits held by each sender
    logic [31:0] exp_q [`MEM_PORTS][$];
    ls_req_t     rnd_q [`MEM_PORTS][$];     // Random traffic per port
    logic [7:0]  shadow [4*(2**`MEM_AW)];
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          err_start;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    mem_subsys u_mem_subsys (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .credit    (credit),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    bind mem_subsys mem_subsys_asserts u_asserts (
        .clk(clk), .rst_n(rst_n), .credit(credit), .rsp_valid(rsp_valid),
        .pop(pop), .push(push), .ram_en(ram_en)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Applies stores to the shadow memory and returns the expected load value
    function automatic logic [31:0] ref_model(input ls_req_t r);
        int          base;
        int          lo;
        logic [7:0]  m [4];
        logic [31:0] res;
        base = 4 * int'(r.addr[`MEM_AW+1:2]);
        lo   = int'(r.addr[1:0]);
        res  = r.rt_data;
        for (int k = 0; k < 4; k++) m[k] = shadow[base+k];
        case (r.sel)
            LS_SEL_SB:  shadow[base+lo] = r.rt_data[7:0];
            LS_SEL_SH: begin
                shadow[base+lo]   = r.rt_data[7:0];
                shadow[base+lo+1] = r.rt_data[15:8];
            end
            LS_SEL_SW:  for (int k = 0; k < 4; k++) shadow[base+k] = r.rt_data[8*k +: 8];
            LS_SEL_SWL: for (int k = 0; k <= lo; k++) shadow[base+k] = r.rt_data[8*(k+3-lo) +: 8];
            LS_SEL_SWR: for (int k = lo; k < 4; k++) shadow[base+k] = r.rt_data[8*(k-lo) +: 8];
            LS_SEL_LB:  res = {{24{m[lo][7]}}, m[lo]};
            LS_SEL_LBU: res = {24'h0, m[lo]};
            LS_SEL_LH:  res = {{16{m[lo+1][7]}}, m[lo+1], m[lo]};
            LS_SEL_LHU: res = {16'h0, m[lo+1], m[lo]};
            LS_SEL_LW:  res = {m[3], m[2], m[1], m[0]};
            LS_SEL_LWL: for (int k = 3 - lo; k < 4; k++) res[8*k +: 8] = m[k-3+lo];
            LS_SEL_LWR: for (int k = 0; k <= 3 - lo; k++) res[8*k +: 8] = m[k+lo];
            default:    res = '0;
        endcase
        return res;
    endfunction

    function automatic ls_req_t make_req(input ls_sel_e sel, input int word, input int lo,
                                         input logic [31:0] rt, input logic exc,
                                         input logic rfe);
        ls_req_t r;
        r.sel           = sel;
        r.addr          = 32'(4 * word + lo);
        r.rt_data       = rt;
        r.has_exception = exc;
        r.refetch       = rfe;
        return r;
    endfunction

    // Each port keeps to its own 16 words so cross-port order never matters
    function automatic ls_req_t rand_req(input int p);
        ls_sel_e kinds [12];
        ls_sel_e s;
        int      lo;
        int      word;
        kinds = '{LS_SEL_SB, LS_SEL_SH, LS_SEL_SW, LS_SEL_SWL, LS_SEL_SWR, LS_SEL_LB,
                  LS_SEL_LBU, LS_SEL_LH, LS_SEL_LHU, LS_SEL_LW, LS_SEL_LWL, LS_SEL_LWR};
        s    = kinds[$unsigned($random(seed)) % 12];
        lo   = $unsigned($random(seed)) % 4;
        word = p * 16 + $unsigned($random(seed)) % 16;
        if (s == LS_SEL_SH || s == LS_SEL_LH || s == LS_SEL_LHU) lo = lo & 2;
        if (s == LS_SEL_SW || s == LS_SEL_LW) lo = 0;
        return make_req(s, word, lo, $random(seed), 1'b0, 1'b0);
    endfunction

    always @(posedge clk) begin
        for (int p = 0; p < `MEM_PORTS; p++) begin
            cnt[p] <= !rst_n ? `MEM_FIFO_DEPTH
                             : cnt[p] + int'(credit[p]) - int'(req_valid[p]);
        end
    end

    // Sends one request as soon as a credit is free after this edge
    task automatic issue(input int p, input ls_req_t r);
        @(posedge clk);
        while (cnt[p] + int'(credit[p]) - int'(req_valid[p]) <= 0) begin
            req_valid[p] <= 1'b0;
            @(posedge clk);
        end
        req_valid[p] <= 1'b1;
        req[p]       <= r;
        if (!(r.has_exception || r.refetch)) begin
            if (r.sel[3]) void'(ref_model(r));
            else exp_q[p].push_back(ref_model(r));
        end
    endtask

    task automatic end_burst(input int p);
        @(posedge clk);
        req_valid[p] <= 1'b0;
    endtask

    task automatic wait_idle();
        bit busy;
        int waited;
        busy = 1'b1;
        while (busy) begin
            @(posedge clk);
            busy = (req_valid != '0);
            for (int p = 0; p < `MEM_PORTS; p++) begin
                busy = busy || exp_q[p].size() != 0;
            end
        end
        // Queued stores still hand their credits back
        busy   = 1'b1;
        waited = 0;
        while (busy && waited < 8 * `MEM_FIFO_DEPTH) begin
            @(posedge clk);
            waited++;
            busy = 1'b0;
            for (int p = 0; p < `MEM_PORTS; p++) begin
                busy = busy || cnt[p] != `MEM_FIFO_DEPTH;
            end
        end
        for (int p = 0; p < `MEM_PORTS; p++) begin
            check_value($sformatf("credit count[%0d]", p), 32'(cnt[p]),
                        32'(`MEM_FIFO_DEPTH));
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d errors", name, errors - err_start);
        err_start = errors;
    endtask

    always @(posedge clk) begin
        for (int p = 0; p < `MEM_PORTS; p++) begin
            if (rst_n && rsp_valid[p]) begin
                if (exp_q[p].size() == 0) begin
                    errors++;
                    $display("Port %0d returned a load response with no load outstanding", p);
                end else begin
                    check_value($sformatf("rsp_data[%0d]", p), rsp_data[p], exp_q[p].pop_front());
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles with requests still pending", cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        req_valid = '0;
        for (int p = 0; p < `MEM_PORTS; p++) req[p] = '0;
        err_start = 0;
        wait (rst_n === 1'b1);
        for (int w = 0; w < 32; w++) issue(0, make_req(LS_SEL_SW, w, 0, $random(seed), 0, 0));
        for (int lo = 0; lo < 4; lo++) issue(0, make_req(LS_SEL_SB, 1, lo, $random(seed), 0, 0));
        for (int lo = 0; lo < 4; lo += 2) issue(0, make_req(LS_SEL_SH, 2, lo, $random(seed), 0, 0));
        for (int w = 0; w < 32; w++) issue(0, make_req(LS_SEL_LW, w, 0, 32'h0, 0, 0));
        end_burst(0);
        wait_idle();
        report_test("store formatting");
        for (int lo = 0; lo < 4; lo++) begin
            issue(0, make_req(LS_SEL_SWL, 4, lo, $random(seed), 0, 0));
            issue(0, make_req(LS_SEL_LW, 4, 0, 32'h0, 0, 0));
            issue(0, make_req(LS_SEL_SWR, 5, lo, $random(seed), 0, 0));
            issue(0, make_req(LS_SEL_LW, 5, 0, 32'h0, 0, 0));
            issue(0, make_req(LS_SEL_LWL, 6, lo, 32'h1122_3344, 0, 0));
            issue(0, make_req(LS_SEL_LWR, 6, lo, 32'h5566_7788, 0, 0));
        end
        end_burst(0);
        wait_idle();
        report_test("partial stores and loads");
        issue(0, make_req(LS_SEL_SW, 7, 0, 32'hc381_f08f, 0, 0));   // Every byte negative
        for (int lo = 0; lo < 4; lo++) begin
            issue(0, make_req(LS_SEL_LB, 7, lo, 32'h0, 0, 0));
            issue(0, make_req(LS_SEL_LBU, 7, lo, 32'h0, 0, 0));
        end
        for (int lo = 0; lo < 4; lo += 2) begin
            issue(0, make_req(LS_SEL_LH, 7, lo, 32'h0, 0, 0));
            issue(0, make_req(LS_SEL_LHU, 7, lo, 32'h0, 0, 0));
        end
        end_burst(0);
        wait_idle();
        report_test("sign extension");
        issue(1, make_req(LS_SEL_SW, 8, 0, 32'hdead_beef, 1, 0));
        issue(1, make_req(LS_SEL_SB, 9, 1, 32'h0000_00aa, 0, 1));
        issue(1, make_req(LS_SEL_LW, 8, 0, 32'h0, 1, 0));
        issue(1, make_req(LS_SEL_LW, 8, 0, 32'h0, 0, 0));
        issue(1, make_req(LS_SEL_LW, 9, 0, 32'h0, 0, 0));
        end_burst(1);
        wait_idle();
        report_test("suppressed requests");
        for (int i = 0; i < 200; i++) begin
            for (int p = 0; p < `MEM_PORTS; p++) rnd_q[p].push_back(rand_req(p));
        end
        fork
            begin
                for (int i = 0; i < 200; i++) issue(0, rnd_q[0][i]);
                end_burst(0);
            end
            begin
                for (int i = 0; i < 200; i++) issue(1, rnd_q[1][i]);
                end_burst(1);
            end
        join
        wait_idle();
        report_test("arbitration and credits");
        errors = errors + u_mem_subsys.u_asserts.fails;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- mem_subsys.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/mem_ctrl.sv
rtl/credit_fifo.sv
rtl/data_arbiter.sv
rtl/data_ram.sv
rtl/load_align.sv
rtl/mem_subsys.sv
verif/tb_clk_gen.sv
verif/mem_subsys_asserts.sv
verif/mem_subsys_tb.sv

//--- Makefile
SRCS := $(filter-out +%,$(shell cat mem_subsys.f))
SIM  := obj_dir/Vmem_subsys_tb

.PHONY: all run clean

all: run

$(SIM): mem_subsys.f rtl/mem_cfg.svh $(SRCS)
	verilator --binary --timing --assert --top-module mem_subsys_tb \
		-f mem_subsys.f -o Vmem_subsys_tb

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TESTS PASSED'

clean:
	rm -rf obj_dir
